// ==== include/mem_pipe_config.svh ====
`ifndef MEM_PIPE_CONFIG_SVH
`define MEM_PIPE_CONFIG_SVH

// --------------------------------------------------------------------------
// data ram geometry
// --------------------------------------------------------------------------

`define MP_MEM_WORDS 64             // depth in 32-bit words.
`define MP_MEM_AW    6              // log2 of the depth.

// the word index wraps modulo the depth, only the low MP_MEM_AW
// index bits reach the ram.

`endif

// ==== source/mem_pipe_pkg.sv ====
package mem_pipe_pkg;

    typedef logic [31:0] word_t;        // data or address word.
    typedef logic [4:0]  reg_addr_t;    // destination register number.

    // ----------------------------------------------------------------------
    // op codes, OP_NOP marks an empty slot
    // ----------------------------------------------------------------------
    typedef enum logic [3:0] {
        OP_NOP = 4'd0,
        OP_ADD = 4'd1,
        OP_SUB = 4'd2,
        OP_AND = 4'd3,
        OP_OR  = 4'd4,
        OP_XOR = 4'd5,
        OP_SLT = 4'd6,                  // signed compare.
        OP_LB  = 4'd7,
        OP_LBU = 4'd8,
        OP_LH  = 4'd9,
        OP_LHU = 4'd10,
        OP_LW  = 4'd11,
        OP_SB  = 4'd12,
        OP_SH  = 4'd13,
        OP_SW  = 4'd14
    } op_e;

    typedef enum logic [1:0] {
        EXC_NONE = 2'd0,
        EXC_ADEL = 2'd1,                // misaligned load.
        EXC_ADES = 2'd2                 // misaligned store.
    } exc_e;

    // ----------------------------------------------------------------------
    // ex result word, decoded as data or as a byte address
    // ----------------------------------------------------------------------
    typedef struct packed {
        logic [29:0] index;             // word index.
        logic [1:0]  offset;            // byte within the word.
    } addr_fields_t;

    typedef union packed {
        word_t        data;             // alu ops.
        addr_fields_t addr;             // loads and stores.
    } result_u;

endpackage

// ==== source/ex_mem_if.sv ====
`timescale 1ns/1ps

// one pipeline slot travelling between stages.
interface ex_mem_if;
    import mem_pipe_pkg::*;

    word_t     pc;
    op_e       op;
    result_u   result;                  // alu data or effective address.
    word_t     store_data;
    reg_addr_t wraddr;

    modport src (
        output pc,
        output op,
        output result,
        output store_data,
        output wraddr
    );

    modport dst (
        input pc,
        input op,
        input result,
        input store_data,
        input wraddr
    );

endinterface

// ==== source/ex_stage.sv ====
`timescale 1ns/1ps

module ex_stage (
    input  mem_pipe_pkg::op_e       op,
    input  mem_pipe_pkg::word_t     pc,
    input  mem_pipe_pkg::word_t     src_a,
    input  mem_pipe_pkg::word_t     src_b,
    input  logic [15:0]             imm,
    input  mem_pipe_pkg::reg_addr_t wraddr,
    ex_mem_if.src                   out
);
    import mem_pipe_pkg::*;

    word_t   imm_sext;
    word_t   eff_addr;
    result_u res;

    assign imm_sext = {{16{imm[15]}}, imm};
    assign eff_addr = src_a + imm_sext;     // base plus offset.

    // ----------------------------------------------------------------------
    // alu result or effective address
    // ----------------------------------------------------------------------
    always_comb begin
        res.data = '0;
        case (op)
            OP_ADD: begin
                res.data = src_a + src_b;
            end
            OP_SUB: begin
                res.data = src_a - src_b;
            end
            OP_AND: begin
                res.data = src_a & src_b;
            end
            OP_OR: begin
                res.data = src_a | src_b;
            end
            OP_XOR: begin
                res.data = src_a ^ src_b;
            end
            OP_SLT: begin
                res.data = {31'd0, $signed(src_a) < $signed(src_b)};
            end
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
            OP_SB, OP_SH, OP_SW: begin
                res.addr = eff_addr;        // address view for memory ops.
            end
            default: begin
                res.data = '0;              // nop carries a zero result.
            end
        endcase
    end

    assign out.pc         = pc;
    assign out.op         = op;
    assign out.result     = res;
    assign out.store_data = src_b;          // store value from rt.
    assign out.wraddr     = wraddr;

endmodule

// ==== source/ex_mem_reg.sv ====
`timescale 1ns/1ps

module ex_mem_reg (
    input  logic  clk,
    input  logic  rst,
    input  logic  stall,
    input  logic  flush,
    ex_mem_if.dst in,
    ex_mem_if.src out
);
    import mem_pipe_pkg::*;

    // ----------------------------------------------------------------------
    // slot register, flush beats stall
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            out.pc         <= '0;
            out.op         <= OP_NOP;
            out.result     <= '0;
            out.store_data <= '0;
            out.wraddr     <= '0;
        end else begin
            if (flush) begin
                out.pc         <= in.pc;        // bubble keeps its pc.
                out.op         <= OP_NOP;
                out.result     <= '0;
                out.store_data <= '0;
                out.wraddr     <= '0;
            end else if (!stall) begin
                out.pc         <= in.pc;
                out.op         <= in.op;
                out.result     <= in.result;
                out.store_data <= in.store_data;
                out.wraddr     <= in.wraddr;
            end
            // stall alone holds the slot.
        end
    end

endmodule

// ==== source/mem_stage.sv ====
`timescale 1ns/1ps
`include "mem_pipe_config.svh"

module mem_stage (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    stall,
    ex_mem_if.dst                   in,
    output logic                    fault,
    output mem_pipe_pkg::exc_e      fault_code,
    output mem_pipe_pkg::word_t     fault_addr,
    output logic                    wb_valid,
    output mem_pipe_pkg::reg_addr_t wb_addr,
    output mem_pipe_pkg::word_t     wb_data,
    output mem_pipe_pkg::word_t     wb_pc
);
    import mem_pipe_pkg::*;

    word_t                 ram [`MP_MEM_WORDS];
    logic [`MP_MEM_AW-1:0] idx;
    logic [1:0]            off;
    logic                  is_load;
    logic                  is_store;
    logic                  is_half;
    logic                  is_word;
    logic                  writes_reg;
    logic                  mem_we;
    logic                  wb_en;
    logic [3:0]            be;
    word_t                 wdata;
    word_t                 rdata;
    logic [7:0]            lane_b;
    logic [15:0]           lane_h;
    word_t                 load_val;

    assign idx = in.result.addr.index[`MP_MEM_AW-1:0];  // wraps modulo depth.
    assign off = in.result.addr.offset;

    // ----------------------------------------------------------------------
    // op decode and alignment check
    // ----------------------------------------------------------------------
    always_comb begin
        is_load    = 1'b0;
        is_store   = 1'b0;
        is_half    = 1'b0;
        is_word    = 1'b0;
        writes_reg = 1'b0;
        case (in.op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT: writes_reg = 1'b1;
            OP_LB, OP_LBU: begin
                is_load    = 1'b1;
                writes_reg = 1'b1;
            end
            OP_LH, OP_LHU: begin
                is_load    = 1'b1;
                is_half    = 1'b1;
                writes_reg = 1'b1;
            end
            OP_LW: begin
                is_load    = 1'b1;
                is_word    = 1'b1;
                writes_reg = 1'b1;
            end
            OP_SB: is_store = 1'b1;
            OP_SH: begin
                is_store = 1'b1;
                is_half  = 1'b1;
            end
            OP_SW: begin
                is_store = 1'b1;
                is_word  = 1'b1;
            end
            default: writes_reg = 1'b0;
        endcase
    end

    assign fault      = (is_half && off[0]) || (is_word && off != 2'd0);
    assign fault_code = !fault ? EXC_NONE : (is_store ? EXC_ADES : EXC_ADEL);
    assign fault_addr = in.result.data;     // bad virtual address.

    // ----------------------------------------------------------------------
    // store lanes, little-endian
    // ----------------------------------------------------------------------
    always_comb begin
        case (in.op)
            OP_SB: begin
                be    = 4'b0001 << off;
                wdata = {4{in.store_data[7:0]}};
            end
            OP_SH: begin
                be    = off[1] ? 4'b1100 : 4'b0011;
                wdata = {2{in.store_data[15:0]}};
            end
            default: begin
                be    = 4'b1111;
                wdata = in.store_data;
            end
        endcase
    end

    assign mem_we = is_store && !fault && !stall;

    always_ff @(posedge clk) begin
        if (mem_we) begin
            for (int i = 0; i < 4; i++) begin
                if (be[i]) begin
                    ram[idx][8*i +: 8] <= wdata[8*i +: 8];
                end
            end
        end
    end

    // load lane select and extension.
    assign rdata  = ram[idx];
    assign lane_b = rdata[8*off +: 8];
    assign lane_h = off[1] ? rdata[31:16] : rdata[15:0];

    always_comb begin
        case (in.op)
            OP_LB:   load_val = {{24{lane_b[7]}}, lane_b};
            OP_LBU:  load_val = {24'd0, lane_b};
            OP_LH:   load_val = {{16{lane_h[15]}}, lane_h};
            OP_LHU:  load_val = {16'd0, lane_h};
            default: load_val = rdata;
        endcase
    end

    // ----------------------------------------------------------------------
    // writeback register
    // ----------------------------------------------------------------------
    assign wb_en = writes_reg && in.wraddr != 5'd0 && !fault && !stall;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wb_valid <= 1'b0;
            wb_addr  <= '0;
            wb_data  <= '0;
            wb_pc    <= '0;
        end else begin
            wb_valid <= wb_en;
            if (wb_en) begin
                wb_addr <= in.wraddr;
                wb_data <= is_load ? load_val : in.result.data;
                wb_pc   <= in.pc;
            end
        end
    end

endmodule

// ==== source/pipe_ctrl.sv ====
`timescale 1ns/1ps

module pipe_ctrl (
    input  logic                clk,
    input  logic                rst,
    input  logic                hold,
    input  logic                fault,
    input  logic                exc_clr,
    input  mem_pipe_pkg::exc_e  fault_code,
    input  mem_pipe_pkg::word_t fault_addr,
    input  mem_pipe_pkg::word_t fault_pc,
    output logic                stall,
    output logic                flush,
    output logic                exc_valid,
    output mem_pipe_pkg::exc_e  exc_code,
    output mem_pipe_pkg::word_t exc_epc,
    output mem_pipe_pkg::word_t exc_badvaddr
);
    import mem_pipe_pkg::*;

    assign stall = hold;                    // environment hold.
    assign flush = fault || exc_valid;      // kill everything behind a fault.

    // ----------------------------------------------------------------------
    // exception state, first fault wins until cleared
    // ----------------------------------------------------------------------
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            exc_valid    <= 1'b0;
            exc_code     <= EXC_NONE;
            exc_epc      <= '0;
            exc_badvaddr <= '0;
        end else if (fault && !exc_valid) begin
            exc_valid    <= 1'b1;
            exc_code     <= fault_code;
            exc_epc      <= fault_pc;
            exc_badvaddr <= fault_addr;
        end else if (exc_clr && !fault) begin
            exc_valid <= 1'b0;
            exc_code  <= EXC_NONE;
        end
    end

endmodule

// ==== source/mem_pipe_top.sv ====
`timescale 1ns/1ps

module mem_pipe_top (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    hold,
    input  logic                    exc_clr,
    input  mem_pipe_pkg::op_e       in_op,
    input  mem_pipe_pkg::word_t     in_pc,
    input  mem_pipe_pkg::word_t     in_src_a,
    input  mem_pipe_pkg::word_t     in_src_b,
    input  logic [15:0]             in_imm,
    input  mem_pipe_pkg::reg_addr_t in_wraddr,
    output logic                    wb_valid,
    output mem_pipe_pkg::reg_addr_t wb_addr,
    output mem_pipe_pkg::word_t     wb_data,
    output mem_pipe_pkg::word_t     wb_pc,
    output logic                    exc_valid,
    output mem_pipe_pkg::exc_e      exc_code,
    output mem_pipe_pkg::word_t     exc_epc,
    output mem_pipe_pkg::word_t     exc_badvaddr
);
    import mem_pipe_pkg::*;

    logic  stall;
    logic  flush;
    logic  fault;
    exc_e  fault_code;
    word_t fault_addr;

    ex_mem_if ex_bus ();                    // ex to ex/mem register.
    ex_mem_if mem_bus ();                   // ex/mem register to mem.

    ex_stage u_ex (
        .op     (in_op),
        .pc     (in_pc),
        .src_a  (in_src_a),
        .src_b  (in_src_b),
        .imm    (in_imm),
        .wraddr (in_wraddr),
        .out    (ex_bus.src)
    );

    ex_mem_reg u_ex_mem (
        .clk   (clk),
        .rst   (rst),
        .stall (stall),
        .flush (flush),
        .in    (ex_bus.dst),
        .out   (mem_bus.src)
    );

    mem_stage u_mem (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .in         (mem_bus.dst),
        .fault      (fault),
        .fault_code (fault_code),
        .fault_addr (fault_addr),
        .wb_valid   (wb_valid),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data),
        .wb_pc      (wb_pc)
    );

    pipe_ctrl u_ctrl (
        .clk          (clk),
        .rst          (rst),
        .hold         (hold),
        .fault        (fault),
        .exc_clr      (exc_clr),
        .fault_code   (fault_code),
        .fault_addr   (fault_addr),
        .fault_pc     (mem_bus.pc),
        .stall        (stall),
        .flush        (flush),
        .exc_valid    (exc_valid),
        .exc_code     (exc_code),
        .exc_epc      (exc_epc),
        .exc_badvaddr (exc_badvaddr)
    );

endmodule

// ==== bench/mem_pipe_tb.sv ====
`timescale 1ns/1ps
`include "mem_pipe_config.svh"

module mem_pipe_tb;
    import mem_pipe_pkg::*;

    localparam int CLK_NS = 8;
    localparam int N_OPS  = 100;            // upper bound on issued ops.

    typedef struct packed {
        op_e         op;
        word_t       pc;
        word_t       a;
        word_t       b;
        logic [15:0] imm;
        reg_addr_t   rd;
    } slot_t;

    logic clk, rst, hold, exc_clr;
    op_e in_op;
    word_t in_pc, in_src_a, in_src_b;
    logic [15:0] in_imm;
    reg_addr_t in_wraddr;
    logic wb_valid, exc_valid;
    reg_addr_t wb_addr;
    word_t wb_data, wb_pc, exc_epc, exc_badvaddr;
    exc_e exc_code;

    // reference pipeline state.
    slot_t ex_m, mem_m;
    logic hold_m, clr_m, hold_req;
    word_t ref_mem [`MP_MEM_WORDS];
    logic exp_wb_valid, exp_exc_valid;
    reg_addr_t exp_wb_addr;
    word_t exp_wb_data, exp_wb_pc, exp_epc, exp_bad;
    exc_e exp_exc_code;
    integer seed;
    word_t pc_next;
    int stored_idx[$];

    mem_pipe_top uut (
        .clk(clk), .rst(rst), .hold(hold), .exc_clr(exc_clr),
        .in_op(in_op), .in_pc(in_pc), .in_src_a(in_src_a), .in_src_b(in_src_b),
        .in_imm(in_imm), .in_wraddr(in_wraddr),
        .wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data), .wb_pc(wb_pc),
        .exc_valid(exc_valid), .exc_code(exc_code), .exc_epc(exc_epc),
        .exc_badvaddr(exc_badvaddr)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    // --------------------------------------------------------------------------
    // failure reporting and compare tasks
    // --------------------------------------------------------------------------
    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("CHECKS FAILED");
        $fatal(1);
    endtask

    task automatic check_word(input word_t got, input word_t exp, input string what);
        if (got !== exp)
            abort_run($sformatf("ERROR at %0t: %s is %h, expected %h", $time, what, got, exp));
    endtask

    task automatic check_reg(input reg_addr_t got, input reg_addr_t exp);
        if (got !== exp)
            abort_run($sformatf("ERROR at %0t: wb_addr is %0d, expected %0d", $time, got, exp));
    endtask

    task automatic check_exc(input exc_e got, input exc_e exp);
        if (got !== exp)
            abort_run($sformatf("ERROR at %0t: exc_code is %0d, expected %0d", $time, got, exp));
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
            abort_run($sformatf("ERROR at %0t: %s is %b, expected %b", $time, what, got, exp));
    endtask

    // --------------------------------------------------------------------------
    // reference model
    // --------------------------------------------------------------------------
    function automatic word_t eff_addr(input slot_t s);
        return s.a + {{16{s.imm[15]}}, s.imm};
    endfunction

    function automatic logic is_load(input op_e op);
        return op inside {OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW};
    endfunction

    function automatic logic is_store(input op_e op);
        return op inside {OP_SB, OP_SH, OP_SW};
    endfunction

    function automatic logic is_alu(input op_e op);
        return op inside {OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT};
    endfunction

    function automatic logic misaligned(input slot_t s);
        word_t ad;
        ad = eff_addr(s);
        case (s.op)
            OP_LH, OP_LHU, OP_SH: return ad[0];
            OP_LW, OP_SW:         return ad[1:0] != 2'd0;
            default:              return 1'b0;
        endcase
    endfunction

    function automatic word_t alu_ref(input slot_t s);
        case (s.op)
            OP_ADD:  return s.a + s.b;
            OP_SUB:  return s.a - s.b;
            OP_AND:  return s.a & s.b;
            OP_OR:   return s.a | s.b;
            OP_XOR:  return s.a ^ s.b;
            default: return ($signed(s.a) < $signed(s.b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    function automatic word_t load_ref(input slot_t s);
        word_t ad;
        word_t w;
        logic [7:0] bt;
        logic [15:0] hf;
        ad = eff_addr(s);
        w  = ref_mem[ad[2 +: `MP_MEM_AW]];         // index wraps with depth.
        case (ad[1:0])
            2'd0:    bt = w[7:0];
            2'd1:    bt = w[15:8];
            2'd2:    bt = w[23:16];
            default: bt = w[31:24];
        endcase
        hf = ad[1] ? w[31:16] : w[15:0];
        case (s.op)
            OP_LB:   return {{24{bt[7]}}, bt};
            OP_LBU:  return {24'd0, bt};
            OP_LH:   return {{16{hf[15]}}, hf};
            OP_LHU:  return {16'd0, hf};
            default: return w;
        endcase
    endfunction

    task automatic store_ref(input slot_t s);
        word_t ad;
        logic [`MP_MEM_AW-1:0] i;
        ad = eff_addr(s);
        i  = ad[2 +: `MP_MEM_AW];
        if (s.op == OP_SW) begin
            ref_mem[i] = s.b;
        end else if (s.op == OP_SH) begin
            if (ad[1]) ref_mem[i][31:16] = s.b[15:0];
            else ref_mem[i][15:0] = s.b[15:0];
        end else begin
            case (ad[1:0])
                2'd0:    ref_mem[i][7:0]   = s.b[7:0];
                2'd1:    ref_mem[i][15:8]  = s.b[7:0];
                2'd2:    ref_mem[i][23:16] = s.b[7:0];
                default: ref_mem[i][31:24] = s.b[7:0];
            endcase
        end
    endtask

    // what one clock edge does to the reference pipeline.
    task automatic model_edge();
        logic f;
        logic fl;
        f  = misaligned(mem_m);
        fl = f || exp_exc_valid;
        exp_wb_valid = 1'b0;
        if ((is_alu(mem_m.op) || is_load(mem_m.op)) && mem_m.rd != 5'd0 && !f && !hold_m) begin
            exp_wb_valid = 1'b1;
            exp_wb_addr  = mem_m.rd;
            exp_wb_data  = is_load(mem_m.op) ? load_ref(mem_m) : alu_ref(mem_m);
            exp_wb_pc    = mem_m.pc;
        end
        if (is_store(mem_m.op) && !f && !hold_m) store_ref(mem_m);
        if (f && !exp_exc_valid) begin
            exp_exc_valid = 1'b1;
            exp_exc_code  = is_store(mem_m.op) ? EXC_ADES : EXC_ADEL;
            exp_epc       = mem_m.pc;
            exp_bad       = eff_addr(mem_m);
        end else if (clr_m && !f) begin
            exp_exc_valid = 1'b0;
            exp_exc_code  = EXC_NONE;
        end
        if (fl) begin
            mem_m    = '0;                          // bubble keeps its pc.
            mem_m.pc = ex_m.pc;
            mem_m.op = OP_NOP;
        end else if (!hold_m) begin
            mem_m = ex_m;
        end
    endtask

    task automatic compare_outputs();
        check_flag(wb_valid, exp_wb_valid, "wb_valid");
        if (exp_wb_valid) begin
            check_reg(wb_addr, exp_wb_addr);
            check_word(wb_data, exp_wb_data, "wb_data");
            check_word(wb_pc, exp_wb_pc, "wb_pc");
        end
        check_flag(exc_valid, exp_exc_valid, "exc_valid");
        check_exc(exc_code, exp_exc_code);
        if (exp_exc_valid) begin
            check_word(exc_epc, exp_epc, "exc_epc");
            check_word(exc_badvaddr, exp_bad, "exc_badvaddr");
        end
    endtask

    // --------------------------------------------------------------------------
    // stimulus
    // --------------------------------------------------------------------------
    task automatic step(input slot_t s, input logic hold_v, input logic clr_v);
        @(posedge clk);
        model_edge();
        ex_m   = s;
        hold_m = hold_v;
        clr_m  = clr_v;
        in_op     <= s.op;
        in_pc     <= s.pc;
        in_src_a  <= s.a;
        in_src_b  <= s.b;
        in_imm    <= s.imm;
        in_wraddr <= s.rd;
        hold      <= hold_v;
        exc_clr   <= clr_v;
        @(negedge clk);
        compare_outputs();
    endtask

    task automatic issue(input op_e op, input word_t a, input word_t b,
                         input logic [15:0] imm, input reg_addr_t rd, input logic clr_v);
        slot_t s;
        s.op  = op;
        s.pc  = pc_next;
        s.a   = a;
        s.b   = b;
        s.imm = imm;
        s.rd  = rd;
        pc_next = pc_next + 32'd4;
        step(s, hold_req, clr_v);
    endtask

    task automatic issue_alu(input op_e op, input word_t a, input word_t b, input reg_addr_t rd);
        issue(op, a, b, 16'd0, rd, 1'b0);
    endtask

    task automatic issue_store(input op_e op, input word_t base, input logic [15:0] imm,
                               input word_t data);
        issue(op, base, data, imm, 5'd0, 1'b0);
    endtask

    task automatic issue_load(input op_e op, input word_t base, input logic [15:0] imm,
                              input reg_addr_t rd);
        issue(op, base, 32'd0, imm, rd, 1'b0);
    endtask

    task automatic issue_nop();
        issue(OP_NOP, 32'd0, 32'd0, 16'd0, 5'd0, 1'b0);
    endtask

    task automatic wait_exc();
        int n;
        n = 0;
        while (exc_valid !== 1'b1) begin
            if (n == 4) abort_run("the exception was never raised");
            issue_nop();
            n++;
        end
    endtask

    // --------------------------------------------------------------------------
    // directed tests
    // --------------------------------------------------------------------------
    task automatic test_alu();
        op_e ops [6];
        ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT};
        for (int i = 0; i < 6; i++) issue_alu(ops[i], $random(seed), $random(seed), 5'(i + 1));
        issue_alu(OP_SLT, 32'hffff_fff0, 32'd3, 5'd8);      // negative vs positive.
        issue_alu(OP_ADD, $random(seed), $random(seed), 5'd0);
        issue_nop();
        issue_nop();
    endtask

    task automatic test_mem();
        int idx;
        for (int i = 0; i < 6; i++) begin
            idx = $random(seed) & 63;
            stored_idx.push_back(idx);
            issue_store(OP_SW, word_t'(idx * 4), 16'd0, $random(seed));
        end
        issue_store(OP_SH, word_t'(stored_idx[0] * 4), 16'd2, $random(seed));
        issue_store(OP_SB, word_t'(stored_idx[1] * 4), 16'd3, $random(seed));
        issue_store(OP_SB, word_t'(stored_idx[1] * 4), 16'd1, 32'h0000_0080);
        issue_load(OP_LW, word_t'((stored_idx[2] + `MP_MEM_WORDS) * 4), 16'd0, 5'd10);
        issue_load(OP_LB, word_t'(stored_idx[1] * 4), 16'd3, 5'd11);
        issue_load(OP_LBU, word_t'(stored_idx[1] * 4), 16'd1, 5'd12);
        issue_load(OP_LB, word_t'(stored_idx[1] * 4), 16'd1, 5'd13);
        issue_load(OP_LH, word_t'(stored_idx[0] * 4), 16'd2, 5'd14);
        issue_load(OP_LHU, word_t'(stored_idx[0] * 4), 16'd0, 5'd15);
        issue_load(OP_LBU, word_t'(stored_idx[3] * 4 + 8), 16'hfff9, 5'd16);
        issue_nop();
        issue_nop();
    endtask

    task automatic test_stall();
        issue_load(OP_LW, word_t'(stored_idx[4] * 4), 16'd0, 5'd7);
        hold_req = 1'b1;
        issue_store(OP_SB, word_t'(stored_idx[4] * 4), 16'd2, $random(seed));
        for (int i = 0; i < 4; i++) step(ex_m, 1'b1, 1'b0);    // same slot held.
        hold_req = 1'b0;
        step(ex_m, 1'b0, 1'b0);                                 // store still presented.
        issue_load(OP_LW, word_t'(stored_idx[4] * 4), 16'd0, 5'd17);
        issue_nop();
        issue_nop();
    endtask

    task automatic test_exc();
        issue_load(OP_LW, word_t'(stored_idx[0] * 4 + 2), 16'd0, 5'd9);
        issue_store(OP_SW, word_t'(stored_idx[5] * 4), 16'd0, $random(seed));
        wait_exc();
        issue(OP_NOP, 32'd0, 32'd0, 16'd0, 5'd0, 1'b1);
        issue_nop();
        issue_store(OP_SH, word_t'(stored_idx[2] * 4), 16'd1, $random(seed));
        issue_store(OP_SW, word_t'(stored_idx[5] * 4), 16'd0, $random(seed));
        wait_exc();
        issue(OP_NOP, 32'd0, 32'd0, 16'd0, 5'd0, 1'b1);
        issue_load(OP_LW, word_t'(stored_idx[5] * 4), 16'd0, 5'd18);
        issue_load(OP_LW, word_t'(stored_idx[2] * 4), 16'd0, 5'd26);
        issue_nop();
        issue_nop();
    endtask

    task automatic test_held();
        issue_load(OP_LHU, word_t'(stored_idx[3] * 4), 16'd1, 5'd19);
        wait_exc();
        for (int i = 0; i < 3; i++) issue_alu(OP_ADD, $random(seed), $random(seed), 5'(20 + i));
        issue(OP_NOP, 32'd0, 32'd0, 16'd0, 5'd0, 1'b1);
        issue_alu(OP_XOR, $random(seed), $random(seed), 5'd24);
        issue_alu(OP_SUB, $random(seed), $random(seed), 5'd25);
        issue_nop();
        issue_nop();
    endtask

    initial begin
        #((N_OPS + 20) * CLK_NS * 4);
        abort_run("watchdog expired before the tests finished");
    end

    initial begin
        seed = 32'h6682_6969;
        rst <= 1'b1;
        hold <= 1'b0;
        exc_clr <= 1'b0;
        in_op <= OP_NOP;
        in_pc <= '0;
        in_src_a <= '0;
        in_src_b <= '0;
        in_imm <= '0;
        in_wraddr <= '0;
        ex_m = '0;
        mem_m = '0;
        hold_m = 1'b0;
        clr_m = 1'b0;
        hold_req = 1'b0;
        exp_wb_valid = 1'b0;
        exp_exc_valid = 1'b0;
        exp_exc_code = EXC_NONE;
        pc_next = 32'h0000_1000;
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        test_alu();
        test_mem();
        test_stall();
        test_exc();
        test_held();
        $display("ALL CHECKS PASSED");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+include
source/mem_pipe_pkg.sv
source/ex_mem_if.sv
source/ex_stage.sv
source/ex_mem_reg.sv
source/mem_stage.sv
source/pipe_ctrl.sv
source/mem_pipe_top.sv
bench/mem_pipe_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the mem_pipe testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module mem_pipe_tb -f build.f -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/Vmem_pipe_tb)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if echo "$out" | grep -q "^ALL CHECKS PASSED$"; then
    exit 0
fi
exit 1
